/* all.f */
hw/mcu_periph_pkg.sv
hw/periph_bridge.sv
hw/apb_decoder.sv
hw/gpio_regs.sv
hw/event_unit.sv
hw/soc_ctrl.sv
hw/mcu_periph_top.sv
verif/mcu_periph_assert.sv
verif/tb_mcu_periph.sv

/* hw/apb_decoder.sv */
`default_nettype none
`timescale 1ns/1ps

module apb_decoder (
  input  logic                                                  psel_i,
  input  mcu_periph_pkg::apb_req_t                              apb_req_i,
  output logic [mcu_periph_pkg::NUM_SLAVES-1:0]                 psel_o,
  input  mcu_periph_pkg::apb_rsp_t [mcu_periph_pkg::NUM_SLAVES-1:0] slv_rsp_i,
  output mcu_periph_pkg::apb_rsp_t                              apb_rsp_o
);

  logic                                  base_hit;
  logic [mcu_periph_pkg::SLOT_W-1:0]     slot;
  logic                                  mapped;
  logic [mcu_periph_pkg::SLV_IDX_W-1:0]  slv_idx;

  // Upper bits must match the peripheral base
  assign base_hit = apb_req_i.paddr[mcu_periph_pkg::ADDR_W-1:mcu_periph_pkg::SLOT_HI+1] ==
                    mcu_periph_pkg::PERIPH_BASE[mcu_periph_pkg::ADDR_W-1:mcu_periph_pkg::SLOT_HI+1];
  assign slot     = apb_req_i.paddr[mcu_periph_pkg::SLOT_HI:mcu_periph_pkg::SLOT_LO];

  always_comb begin
    mapped  = 1'b0;
    slv_idx = '0;
    if (base_hit) begin
      case (slot)
        mcu_periph_pkg::SLOT_GPIO: begin
          mapped  = 1'b1;
          slv_idx = mcu_periph_pkg::SLV_IDX_W'(mcu_periph_pkg::SLV_GPIO);
        end
        mcu_periph_pkg::SLOT_EVENT: begin
          mapped  = 1'b1;
          slv_idx = mcu_periph_pkg::SLV_IDX_W'(mcu_periph_pkg::SLV_EVENT);
        end
        mcu_periph_pkg::SLOT_SOC: begin
          mapped  = 1'b1;
          slv_idx = mcu_periph_pkg::SLV_IDX_W'(mcu_periph_pkg::SLV_SOC);
        end
        default: mapped = 1'b0; // UART slot included
      endcase
    end
  end

  always_comb begin
    psel_o = '0;
    if (psel_i && mapped) psel_o[slv_idx] = 1'b1;
  end

  // Unmapped access completes at once with an error
  always_comb begin
    if (mapped) begin
      apb_rsp_o = slv_rsp_i[slv_idx];
    end else begin
      apb_rsp_o = '{prdata: '0, pready: 1'b1, pslverr: 1'b1};
    end
  end

endmodule

`default_nettype wire

/* hw/event_unit.sv */
`default_nettype none
`timescale 1ns/1ps

module event_unit (
  input  logic                                 clock,
  input  logic                                 rst_n_i,
  input  logic                                 psel_i,
  input  mcu_periph_pkg::apb_req_t             apb_req_i,
  output mcu_periph_pkg::apb_rsp_t             apb_rsp_o,
  input  logic                                 gpio_event_i,
  output logic                                 irq_o,
  output logic [mcu_periph_pkg::IRQ_ID_W-1:0]  irq_id_o
);

  logic [mcu_periph_pkg::OFFS_W-1:0] offs;
  logic                              offs_ok;
  logic                              wr_en;
  logic [mcu_periph_pkg::DATA_W-1:0] rdata;
  logic [mcu_periph_pkg::IRQ_W-1:0]  enable_q;
  logic [mcu_periph_pkg::IRQ_W-1:0]  pending;
  logic [mcu_periph_pkg::IRQ_W-1:0]  active;

  assign offs  = apb_req_i.paddr[mcu_periph_pkg::OFFS_W-1:0];
  assign wr_en = psel_i & apb_req_i.penable & apb_req_i.pwrite & offs_ok;

  // Only the GPIO line is wired, UART line stays idle
  always_comb begin
    pending = '0;
    pending[mcu_periph_pkg::IRQ_GPIO_BIT] = gpio_event_i;
  end

  always_comb begin
    offs_ok = 1'b1;
    rdata   = '0;
    case (offs)
      mcu_periph_pkg::EVT_ENABLE:  rdata = enable_q;
      mcu_periph_pkg::EVT_PENDING: rdata = pending;
      default:                     offs_ok = 1'b0;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q <= '0;
    end else if (wr_en && offs == mcu_periph_pkg::EVT_ENABLE) begin
      enable_q <= apb_req_i.pwdata;
    end
  end

  assign active = pending & enable_q;
  assign irq_o  = |active;

  // Highest active line wins
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < mcu_periph_pkg::IRQ_W; i++) begin
      if (active[i]) irq_id_o = i[mcu_periph_pkg::IRQ_ID_W-1:0];
    end
  end

  assign apb_rsp_o = '{prdata: rdata, pready: 1'b1, pslverr: psel_i & ~offs_ok};

endmodule

`default_nettype wire

/* hw/gpio_regs.sv */
`default_nettype none
`timescale 1ns/1ps

module gpio_regs (
  input  logic                                clock,
  input  logic                                rst_n_i,
  input  logic                                psel_i,
  input  mcu_periph_pkg::apb_req_t            apb_req_i,
  output mcu_periph_pkg::apb_rsp_t            apb_rsp_o,
  input  logic [mcu_periph_pkg::GPIO_W-1:0]   gpio_in_i,
  output logic [mcu_periph_pkg::GPIO_W-1:0]   gpio_out_o,
  output logic [mcu_periph_pkg::GPIO_W-1:0]   gpio_dir_o,
  output logic                                event_o
);

  logic [mcu_periph_pkg::OFFS_W-1:0] offs;
  logic                              offs_ok;
  logic                              wr_en;
  logic [mcu_periph_pkg::DATA_W-1:0] rdata;
  logic [mcu_periph_pkg::GPIO_W-1:0] dir_q;
  logic [mcu_periph_pkg::GPIO_W-1:0] out_q;
  logic [mcu_periph_pkg::GPIO_W-1:0] inten_q;
  logic [mcu_periph_pkg::GPIO_W-1:0] stat_q;
  logic [mcu_periph_pkg::GPIO_W-1:0] sync1_q;
  logic [mcu_periph_pkg::GPIO_W-1:0] sync2_q;
  logic [mcu_periph_pkg::GPIO_W-1:0] prev_q;
  logic [mcu_periph_pkg::GPIO_W-1:0] rise;
  logic [mcu_periph_pkg::GPIO_W-1:0] stat_clr;

  assign offs  = apb_req_i.paddr[mcu_periph_pkg::OFFS_W-1:0];
  assign wr_en = psel_i & apb_req_i.penable & apb_req_i.pwrite & offs_ok;

  // Read mux, also flags unknown offsets
  always_comb begin
    offs_ok = 1'b1;
    rdata   = '0;
    case (offs)
      mcu_periph_pkg::GPIO_DIR:     rdata = dir_q;
      mcu_periph_pkg::GPIO_IN:      rdata = sync2_q;
      mcu_periph_pkg::GPIO_OUT:     rdata = out_q;
      mcu_periph_pkg::GPIO_INTEN:   rdata = inten_q;
      mcu_periph_pkg::GPIO_INTSTAT: rdata = stat_q;
      default:                      offs_ok = 1'b0;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dir_q   <= '0;
      out_q   <= '0;
      inten_q <= '0;
    end else if (wr_en) begin
      case (offs)
        mcu_periph_pkg::GPIO_DIR:   dir_q   <= apb_req_i.pwdata;
        mcu_periph_pkg::GPIO_OUT:   out_q   <= apb_req_i.pwdata;
        mcu_periph_pkg::GPIO_INTEN: inten_q <= apb_req_i.pwdata;
        default: ; // GPIO_IN is read only
      endcase
    end
  end

  // Two flops for metastability, third for edge detect
  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_in_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  assign rise     = sync2_q & ~prev_q;
  assign stat_clr = (wr_en && offs == mcu_periph_pkg::GPIO_INTSTAT) ? apb_req_i.pwdata : '0;

  // A new edge wins over a clear in the same cycle
  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stat_q <= '0;
    end else begin
      stat_q <= (stat_q & ~stat_clr) | (rise & inten_q);
    end
  end

  assign event_o    = |stat_q;
  assign gpio_out_o = out_q;
  assign gpio_dir_o = dir_q;
  assign apb_rsp_o  = '{prdata: rdata, pready: 1'b1, pslverr: psel_i & ~offs_ok};

endmodule

`default_nettype wire

/* hw/mcu_periph_pkg.sv */
`default_nettype none

package mcu_periph_pkg;

  // Bus widths
  localparam int unsigned ADDR_W   = 32;
  localparam int unsigned DATA_W   = 32;
  localparam int unsigned GPIO_W   = 32;
  localparam int unsigned IRQ_W    = 32;
  localparam int unsigned IRQ_ID_W = 5;

  localparam int unsigned IRQ_GPIO_BIT = 25; // GPIO event line

  // Peripheral map, one 4 KB slot per peripheral
  localparam logic [ADDR_W-1:0] PERIPH_BASE = 32'h1A10_0000;
  localparam int unsigned SLOT_HI = 15;
  localparam int unsigned SLOT_LO = 12;
  localparam int unsigned SLOT_W  = SLOT_HI - SLOT_LO + 1;
  localparam int unsigned OFFS_W  = SLOT_LO;

  localparam logic [SLOT_W-1:0] SLOT_GPIO  = 4'd1;
  localparam logic [SLOT_W-1:0] SLOT_SOC   = 4'd3;
  localparam logic [SLOT_W-1:0] SLOT_EVENT = 4'd4; // Slot 0 was the UART

  // Slave positions in the select vector
  localparam int unsigned NUM_SLAVES = 3;
  localparam int unsigned SLV_IDX_W  = $clog2(NUM_SLAVES);
  localparam int unsigned SLV_GPIO   = 0;
  localparam int unsigned SLV_EVENT  = 1;
  localparam int unsigned SLV_SOC    = 2;

  // GPIO registers
  localparam logic [OFFS_W-1:0] GPIO_DIR     = 12'h000;
  localparam logic [OFFS_W-1:0] GPIO_IN      = 12'h004;
  localparam logic [OFFS_W-1:0] GPIO_OUT     = 12'h008;
  localparam logic [OFFS_W-1:0] GPIO_INTEN   = 12'h00C;
  localparam logic [OFFS_W-1:0] GPIO_INTSTAT = 12'h010; // Write 1 to clear

  // Event unit registers
  localparam logic [OFFS_W-1:0] EVT_ENABLE  = 12'h000;
  localparam logic [OFFS_W-1:0] EVT_PENDING = 12'h004;

  // SoC control registers
  localparam logic [OFFS_W-1:0] SOC_BOOT  = 12'h000;
  localparam logic [OFFS_W-1:0] SOC_FETCH = 12'h004;

  localparam logic [ADDR_W-1:0] BOOT_RESET = 32'h0000_8000;

  // Bridge sequencer states
  localparam int unsigned BR_ST_W = 2;
  localparam logic [BR_ST_W-1:0] ST_IDLE   = 2'd0;
  localparam logic [BR_ST_W-1:0] ST_SETUP  = 2'd1;
  localparam logic [BR_ST_W-1:0] ST_ACCESS = 2'd2;
  localparam logic [BR_ST_W-1:0] ST_RESP   = 2'd3;

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } bus_rsp_t;

  // psel is carried separately per slave
  typedef struct packed {
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

/* hw/mcu_periph_top.sv */
`default_nettype none
`timescale 1ns/1ps

module mcu_periph_top (
  input  logic                                clock,
  input  logic                                rst_n_i,
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  mcu_periph_pkg::bus_req_t            req_i,
  output logic                                rsp_valid_o,
  input  logic                                rsp_ready_i,
  output mcu_periph_pkg::bus_rsp_t            rsp_o,
  input  logic [mcu_periph_pkg::GPIO_W-1:0]   gpio_in_i,
  output logic [mcu_periph_pkg::GPIO_W-1:0]   gpio_out_o,
  output logic [mcu_periph_pkg::GPIO_W-1:0]   gpio_dir_o,
  output logic                                irq_o,
  output logic [mcu_periph_pkg::IRQ_ID_W-1:0] irq_id_o,
  input  logic                                fetch_enable_i,
  output logic                                fetch_enable_o,
  output logic [mcu_periph_pkg::ADDR_W-1:0]   boot_addr_o
);

  logic                                                      psel;
  mcu_periph_pkg::apb_req_t                                  apb_req;  // Shared by all slaves
  mcu_periph_pkg::apb_rsp_t                                  apb_rsp;
  logic [mcu_periph_pkg::NUM_SLAVES-1:0]                     slv_psel;
  mcu_periph_pkg::apb_rsp_t [mcu_periph_pkg::NUM_SLAVES-1:0] slv_rsp;
  logic                                                      gpio_event;

  periph_bridge u_bridge (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o),
    .psel_o      (psel),
    .apb_req_o   (apb_req),
    .apb_rsp_i   (apb_rsp)
  );

  apb_decoder u_decoder (
    .psel_i    (psel),
    .apb_req_i (apb_req),
    .psel_o    (slv_psel),
    .slv_rsp_i (slv_rsp),
    .apb_rsp_o (apb_rsp)
  );

  gpio_regs u_gpio (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .psel_i     (slv_psel[mcu_periph_pkg::SLV_GPIO]),
    .apb_req_i  (apb_req),
    .apb_rsp_o  (slv_rsp[mcu_periph_pkg::SLV_GPIO]),
    .gpio_in_i  (gpio_in_i),
    .gpio_out_o (gpio_out_o),
    .gpio_dir_o (gpio_dir_o),
    .event_o    (gpio_event)
  );

  event_unit u_event (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .psel_i       (slv_psel[mcu_periph_pkg::SLV_EVENT]),
    .apb_req_i    (apb_req),
    .apb_rsp_o    (slv_rsp[mcu_periph_pkg::SLV_EVENT]),
    .gpio_event_i (gpio_event),
    .irq_o        (irq_o),
    .irq_id_o     (irq_id_o)
  );

  soc_ctrl u_soc (
    .clock          (clock),
    .rst_n_i        (rst_n_i),
    .psel_i         (slv_psel[mcu_periph_pkg::SLV_SOC]),
    .apb_req_i      (apb_req),
    .apb_rsp_o      (slv_rsp[mcu_periph_pkg::SLV_SOC]),
    .fetch_enable_i (fetch_enable_i),
    .fetch_enable_o (fetch_enable_o),
    .boot_addr_o    (boot_addr_o)
  );

endmodule

`default_nettype wire

/* hw/periph_bridge.sv */
`default_nettype none
`timescale 1ns/1ps

module periph_bridge (
  input  logic                     clock,
  input  logic                     rst_n_i,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  mcu_periph_pkg::bus_req_t req_i,
  output logic                     rsp_valid_o,
  input  logic                     rsp_ready_i,
  output mcu_periph_pkg::bus_rsp_t rsp_o,
  output logic                     psel_o,
  output mcu_periph_pkg::apb_req_t apb_req_o,
  input  mcu_periph_pkg::apb_rsp_t apb_rsp_i
);

  logic [mcu_periph_pkg::BR_ST_W-1:0] state_q;
  logic [mcu_periph_pkg::BR_ST_W-1:0] state_d;
  mcu_periph_pkg::bus_req_t           req_q;
  mcu_periph_pkg::bus_rsp_t           rsp_q;
  logic                               accept;
  logic                               done;

  assign accept = req_valid_i & req_ready_o;
  assign done   = (state_q == mcu_periph_pkg::ST_ACCESS) & apb_rsp_i.pready;

  // One transfer in flight, response held until taken
  always_comb begin
    state_d = state_q;
    case (state_q)
      mcu_periph_pkg::ST_IDLE: begin
        if (accept) state_d = mcu_periph_pkg::ST_SETUP;
      end
      mcu_periph_pkg::ST_SETUP:  state_d = mcu_periph_pkg::ST_ACCESS;
      mcu_periph_pkg::ST_ACCESS: begin
        if (done) state_d = mcu_periph_pkg::ST_RESP; // Wait states stay here
      end
      mcu_periph_pkg::ST_RESP: begin
        if (rsp_ready_i) state_d = mcu_periph_pkg::ST_IDLE;
      end
      default: state_d = mcu_periph_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= mcu_periph_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      req_q <= req_i;
    end
    if (done) begin
      rsp_q.rdata <= apb_rsp_i.prdata;
      rsp_q.err   <= apb_rsp_i.pslverr;
    end
  end

  assign req_ready_o = (state_q == mcu_periph_pkg::ST_IDLE);
  assign rsp_valid_o = (state_q == mcu_periph_pkg::ST_RESP);
  assign rsp_o       = rsp_q;

  // Setup and access phases
  assign psel_o    = (state_q == mcu_periph_pkg::ST_SETUP) |
                     (state_q == mcu_periph_pkg::ST_ACCESS);
  assign apb_req_o = '{penable: (state_q == mcu_periph_pkg::ST_ACCESS),
                       pwrite:  req_q.we,
                       paddr:   req_q.addr,
                       pwdata:  req_q.wdata};

endmodule

`default_nettype wire

/* hw/soc_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module soc_ctrl (
  input  logic                               clock,
  input  logic                               rst_n_i,
  input  logic                               psel_i,
  input  mcu_periph_pkg::apb_req_t           apb_req_i,
  output mcu_periph_pkg::apb_rsp_t           apb_rsp_o,
  input  logic                               fetch_enable_i,
  output logic                               fetch_enable_o,
  output logic [mcu_periph_pkg::ADDR_W-1:0]  boot_addr_o
);

  logic [mcu_periph_pkg::OFFS_W-1:0] offs;
  logic                              offs_ok;
  logic                              wr_en;
  logic [mcu_periph_pkg::DATA_W-1:0] rdata;
  logic [mcu_periph_pkg::ADDR_W-1:2] boot_q;  // Word aligned
  logic                              fetch_q;

  assign offs  = apb_req_i.paddr[mcu_periph_pkg::OFFS_W-1:0];
  assign wr_en = psel_i & apb_req_i.penable & apb_req_i.pwrite & offs_ok;

  always_comb begin
    offs_ok = 1'b1;
    rdata   = '0;
    case (offs)
      mcu_periph_pkg::SOC_BOOT:  rdata = boot_addr_o;
      mcu_periph_pkg::SOC_FETCH: rdata[0] = fetch_q;
      default:                   offs_ok = 1'b0;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      boot_q  <= mcu_periph_pkg::BOOT_RESET[mcu_periph_pkg::ADDR_W-1:2];
      fetch_q <= 1'b1;  // Core may fetch out of reset
    end else if (wr_en) begin
      case (offs)
        mcu_periph_pkg::SOC_BOOT:  boot_q  <= apb_req_i.pwdata[mcu_periph_pkg::ADDR_W-1:2];
        mcu_periph_pkg::SOC_FETCH: fetch_q <= apb_req_i.pwdata[0];
        default: ;
      endcase
    end
  end

  assign boot_addr_o    = {boot_q, 2'b00};
  assign fetch_enable_o = fetch_enable_i & fetch_q;
  assign apb_rsp_o      = '{prdata: rdata, pready: 1'b1, pslverr: psel_i & ~offs_ok};

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the peripheral subsystem testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --top-module tb_mcu_periph \
  --Mdir "$build_dir" -o sim_mcu_periph -f all.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/sim_mcu_periph" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "SIMULATION PASSED" "$log_file"; then
  exit 0
fi
echo "Pass message not found in $log_file"
exit 1

/* verif/mcu_periph_assert.sv */
`default_nettype none
`timescale 1ns/1ps

module mcu_periph_assert (
  input logic                                  clock,
  input logic                                  rst_n_i,
  input logic                                  req_valid_i,
  input logic                                  req_ready_i,
  input mcu_periph_pkg::bus_req_t              req_i,
  input logic                                  rsp_valid_i,
  input logic                                  rsp_ready_i,
  input mcu_periph_pkg::bus_rsp_t              rsp_i,
  input logic                                  psel_i,
  input logic                                  penable_i,
  input logic [mcu_periph_pkg::NUM_SLAVES-1:0] slv_psel_i
);

  // Waiting request keeps its payload
  a_req_stable: assert property (@(posedge clock) disable iff (!rst_n_i)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
    else $error("request changed while waiting for req_ready_o");

  a_rsp_stable: assert property (@(posedge clock) disable iff (!rst_n_i)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
    else $error("response changed or dropped before it was taken");

  // Setup phase is always followed by access
  a_setup_access: assert property (@(posedge clock) disable iff (!rst_n_i)
    psel_i && !penable_i |=> psel_i && penable_i)
    else $error("APB setup phase not followed by access phase");

  a_psel_onehot: assert property (@(posedge clock) disable iff (!rst_n_i)
    $onehot0(slv_psel_i))
    else $error("more than one APB slave selected");

endmodule

`default_nettype wire

/* verif/tb_mcu_periph.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_mcu_periph;

  localparam logic [31:0] GPIO_BASE = mcu_periph_pkg::PERIPH_BASE + 32'h0000_1000;
  localparam logic [31:0] SOC_BASE  = mcu_periph_pkg::PERIPH_BASE + 32'h0000_3000;
  localparam logic [31:0] EVT_BASE  = mcu_periph_pkg::PERIPH_BASE + 32'h0000_4000;
  localparam logic [31:0] UART_BASE = mcu_periph_pkg::PERIPH_BASE;
  localparam logic [31:0] FAR_ADDR  = 32'h1A11_1000; // Slot 1 but wrong base
  localparam int unsigned SEED      = 32'hc0b7_df33;

  typedef struct packed {
    logic                                 we;
    logic [mcu_periph_pkg::ADDR_W-1:0]    addr;
    logic [mcu_periph_pkg::DATA_W-1:0]    wdata;
    logic [mcu_periph_pkg::GPIO_W-1:0]    gpio_in;
    logic                                 fetch_en;
    logic [mcu_periph_pkg::DATA_W-1:0]    exp_rdata;
    logic                                 exp_err;
    logic                                 exp_irq;
    logic [mcu_periph_pkg::IRQ_ID_W-1:0]  exp_id;
  } row_t;

  logic                                clock;
  logic                                rst_n_i;
  logic                                req_valid_i;
  logic                                req_ready_o;
  mcu_periph_pkg::bus_req_t            req_i;
  logic                                rsp_valid_o;
  logic                                rsp_ready_i;
  mcu_periph_pkg::bus_rsp_t            rsp_o;
  logic [mcu_periph_pkg::GPIO_W-1:0]   gpio_in_i;
  logic [mcu_periph_pkg::GPIO_W-1:0]   gpio_out_o;
  logic [mcu_periph_pkg::GPIO_W-1:0]   gpio_dir_o;
  logic                                irq_o;
  logic [mcu_periph_pkg::IRQ_ID_W-1:0] irq_id_o;
  logic                                fetch_enable_i;
  logic                                fetch_enable_o;
  logic [mcu_periph_pkg::ADDR_W-1:0]   boot_addr_o;

  row_t        rows[$];
  int          err_count;
  int          check_count;
  int          cycle_count;
  int          cycle_limit;
  logic [31:0] exp_dir;   // Reference state of the output registers
  logic [31:0] exp_out;
  logic [31:0] exp_boot;
  logic        exp_gate;

  mcu_periph_top u_dut (.*);

  bind mcu_periph_top mcu_periph_assert u_assert (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_i (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_i (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_i       (rsp_o),
    .psel_i      (psel),
    .penable_i   (apb_req.penable),
    .slv_psel_i  (slv_psel)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // Random back-pressure on the response port
  initial begin
    void'($urandom(SEED));
    rsp_ready_i = 1'b0;
    forever begin
      @(posedge clock);
      rsp_ready_i <= ($urandom % 4) != 0;
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_limit == 0 || cycle_count < cycle_limit) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("SIMULATION FAILED");
    $finish;
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp, act);
    err_count++;
    $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
  endtask

  task automatic check_rsp(input mcu_periph_pkg::bus_rsp_t exp, act, input logic is_write);
    check_count++;
    if (!is_write && act.rdata !== exp.rdata) report_mismatch("rsp_o.rdata", exp.rdata, act.rdata);
    if (act.err !== exp.err) report_mismatch("rsp_o.err", 32'(exp.err), 32'(act.err));
  endtask

  task automatic check_pins(input string name,
                            input logic [mcu_periph_pkg::GPIO_W-1:0] exp, act);
    check_count++;
    if (act !== exp) report_mismatch(name, exp, act);
  endtask

  task automatic check_irq(input logic exp_irq, input logic [mcu_periph_pkg::IRQ_ID_W-1:0] exp_id,
                           input logic act_irq, input logic [mcu_periph_pkg::IRQ_ID_W-1:0] act_id);
    check_count++;
    if (act_irq !== exp_irq) report_mismatch("irq_o", 32'(exp_irq), 32'(act_irq));
    if (act_id !== exp_id) report_mismatch("irq_id_o", 32'(exp_id), 32'(act_id));
  endtask

  task automatic check_boot(input logic [mcu_periph_pkg::ADDR_W-1:0] exp, act);
    check_count++;
    if (act !== exp) report_mismatch("boot_addr_o", exp, act);
  endtask

  task automatic check_flag(input string name, input logic exp, act);
    check_count++;
    if (act !== exp) report_mismatch(name, 32'(exp), 32'(act));
  endtask

  task automatic check_latency(input int exp, act);
    check_count++;
    if (act != exp) report_mismatch("response latency", 32'(exp), 32'(act));
  endtask

  task automatic add_row(input logic we, input logic [31:0] addr, wdata, gpio_in,
                         input logic fetch_en, input logic [31:0] exp_rdata,
                         input logic exp_err, exp_irq, input logic [4:0] exp_id);
    rows.push_back('{we, addr, wdata, gpio_in, fetch_en, exp_rdata, exp_err, exp_irq, exp_id});
  endtask

  task automatic fill_table();
    // Reset values
    add_row(1'b0, SOC_BASE + 32'h0, 32'h0, 32'h0, 1'b1, 32'h0000_8000, 1'b0, 1'b0, 5'd0);
    add_row(1'b0, SOC_BASE + 32'h4, 32'h0, 32'h0, 1'b1, 32'h0000_0001, 1'b0, 1'b0, 5'd0);
    add_row(1'b0, GPIO_BASE + 32'h0, 32'h0, 32'h0, 1'b1, 32'h0, 1'b0, 1'b0, 5'd0);
    add_row(1'b0, GPIO_BASE + 32'h8, 32'h0, 32'h0, 1'b1, 32'h0, 1'b0, 1'b0, 5'd0);
    add_row(1'b0, EVT_BASE + 32'h0, 32'h0, 32'h0, 1'b1, 32'h0, 1'b0, 1'b0, 5'd0);
    // GPIO write and readback
    add_row(1'b1, GPIO_BASE + 32'h0, 32'h0000_00FF, 32'h0, 1'b1, 32'h0, 1'b0, 1'b0, 5'd0);
    add_row(1'b0, GPIO_BASE + 32'h0, 32'h0, 32'h0, 1'b1, 32'h0000_00FF, 1'b0, 1'b0, 5'd0);
    add_row(1'b1, GPIO_BASE + 32'h8, 32'hA5A5_0F0F, 32'h0, 1'b1, 32'h0, 1'b0, 1'b0, 5'd0);
    add_row(1'b0, GPIO_BASE + 32'h8, 32'h0, 32'h0, 1'b1, 32'hA5A5_0F0F, 1'b0, 1'b0, 5'd0);
    add_row(1'b0, GPIO_BASE + 32'h4, 32'h0, 32'h1234_5678, 1'b1, 32'h1234_5678, 1'b0, 1'b0, 5'd0);
    // Interrupt on pin 3 through event line 25
    add_row(1'b1, GPIO_BASE + 32'hC, 32'h0000_0008, 32'h0, 1'b1, 32'h0, 1'b0, 1'b0, 5'd0);
    add_row(1'b1, EVT_BASE + 32'h0, 32'h0200_0000, 32'h0, 1'b1, 32'h0, 1'b0, 1'b0, 5'd0);
    add_row(1'b0, GPIO_BASE + 32'h10, 32'h0, 32'h8, 1'b1, 32'h0000_0008, 1'b0, 1'b1, 5'd25);
    add_row(1'b0, EVT_BASE + 32'h4, 32'h0, 32'h8, 1'b1, 32'h0200_0000, 1'b0, 1'b1, 5'd25);
    add_row(1'b1, GPIO_BASE + 32'h10, 32'h0000_0008, 32'h8, 1'b1, 32'h0, 1'b0, 1'b0, 5'd0);
    add_row(1'b0, GPIO_BASE + 32'h10, 32'h0, 32'h8, 1'b1, 32'h0, 1'b0, 1'b0, 5'd0);
    add_row(1'b1, EVT_BASE + 32'h0, 32'h0, 32'h0, 1'b1, 32'h0, 1'b0, 1'b0, 5'd0);
    add_row(1'b0, GPIO_BASE + 32'h10, 32'h0, 32'h8, 1'b1, 32'h0000_0008, 1'b0, 1'b0, 5'd0);
    add_row(1'b1, GPIO_BASE + 32'h10, 32'h0000_0008, 32'h8, 1'b1, 32'h0, 1'b0, 1'b0, 5'd0);
    // Error responses, registers stay unchanged
    add_row(1'b1, UART_BASE, 32'hDEAD_BEEF, 32'h0, 1'b1, 32'h0, 1'b1, 1'b0, 5'd0);
    add_row(1'b0, UART_BASE, 32'h0, 32'h0, 1'b1, 32'h0, 1'b1, 1'b0, 5'd0);
    add_row(1'b1, FAR_ADDR, 32'hFFFF_FFFF, 32'h0, 1'b1, 32'h0, 1'b1, 1'b0, 5'd0);
    add_row(1'b1, GPIO_BASE + 32'h20, 32'hFFFF_FFFF, 32'h0, 1'b1, 32'h0, 1'b1, 1'b0, 5'd0);
    add_row(1'b0, GPIO_BASE + 32'h0, 32'h0, 32'h0, 1'b1, 32'h0000_00FF, 1'b0, 1'b0, 5'd0);
    add_row(1'b1, SOC_BASE + 32'h8, 32'h0000_1234, 32'h0, 1'b1, 32'h0, 1'b1, 1'b0, 5'd0);
    add_row(1'b0, SOC_BASE + 32'h0, 32'h0, 32'h0, 1'b1, 32'h0000_8000, 1'b0, 1'b0, 5'd0);
    // Boot address and fetch gate
    add_row(1'b1, SOC_BASE + 32'h0, 32'h0000_1237, 32'h0, 1'b1, 32'h0, 1'b0, 1'b0, 5'd0);
    add_row(1'b0, SOC_BASE + 32'h0, 32'h0, 32'h0, 1'b1, 32'h0000_1234, 1'b0, 1'b0, 5'd0);
    add_row(1'b1, SOC_BASE + 32'h4, 32'h0, 32'h0, 1'b1, 32'h0, 1'b0, 1'b0, 5'd0);
    add_row(1'b0, SOC_BASE + 32'h4, 32'h0, 32'h0, 1'b1, 32'h0, 1'b0, 1'b0, 5'd0);
    add_row(1'b1, SOC_BASE + 32'h4, 32'h0000_0001, 32'h0, 1'b1, 32'h0, 1'b0, 1'b0, 5'd0);
    add_row(1'b0, SOC_BASE + 32'h4, 32'h0, 32'h0, 1'b0, 32'h0000_0001, 1'b0, 1'b0, 5'd0);
  endtask

  task automatic update_model(input row_t r);
    if (r.we && !r.exp_err) begin
      case (r.addr)
        GPIO_BASE + 32'h0: exp_dir = r.wdata;
        GPIO_BASE + 32'h8: exp_out = r.wdata;
        SOC_BASE + 32'h0:  exp_boot = r.wdata & 32'hFFFF_FFFC;
        SOC_BASE + 32'h4:  exp_gate = r.wdata[0];
        default: ;
      endcase
    end
  endtask

  task automatic run_row(input row_t r);
    int                       lat;
    logic                     stalled;
    mcu_periph_pkg::bus_rsp_t exp_rsp;
    @(posedge clock);
    gpio_in_i      <= r.gpio_in;
    fetch_enable_i <= r.fetch_en;
    repeat (4) @(posedge clock);  // Synchronizer and edge detect settle
    req_i       <= '{we: r.we, addr: r.addr, wdata: r.wdata};
    req_valid_i <= 1'b1;
    @(negedge clock);
    while (!req_ready_o) @(negedge clock);
    @(posedge clock);             // Acceptance edge
    req_valid_i <= 1'b0;
    lat     = 0;
    stalled = 1'b0;
    do begin
      @(negedge clock);
      lat++;
      if (rsp_valid_o && !rsp_ready_i) stalled = 1'b1;
    end while (!(rsp_valid_o && rsp_ready_i));
    if (!stalled) check_latency(3, lat);
    exp_rsp = '{rdata: r.exp_rdata, err: r.exp_err};
    update_model(r);
    check_rsp(exp_rsp, rsp_o, r.we);
    check_irq(r.exp_irq, r.exp_id, irq_o, irq_id_o);
    check_pins("gpio_dir_o", exp_dir, gpio_dir_o);
    check_pins("gpio_out_o", exp_out, gpio_out_o);
    check_boot(exp_boot, boot_addr_o);
    check_flag("fetch_enable_o", r.fetch_en & exp_gate, fetch_enable_o);
  endtask

  initial begin
    rst_n_i        = 1'b0;
    req_valid_i    = 1'b0;
    req_i          = '0;
    gpio_in_i      = '0;
    fetch_enable_i = 1'b1;
    err_count      = 0;
    check_count    = 0;
    exp_dir        = '0;
    exp_out        = '0;
    exp_boot       = mcu_periph_pkg::BOOT_RESET;
    exp_gate       = 1'b1;
    fill_table();
    cycle_limit = rows.size() * 20 + 100;
    repeat (16) @(posedge clock);
    rst_n_i <= 1'b1;
    @(negedge clock);
    check_flag("req_ready_o", 1'b1, req_ready_o);
    check_flag("rsp_valid_o", 1'b0, rsp_valid_o);
    check_irq(1'b0, '0, irq_o, irq_id_o);
    check_pins("gpio_dir_o", '0, gpio_dir_o);
    check_pins("gpio_out_o", '0, gpio_out_o);
    check_flag("fetch_enable_o", 1'b1, fetch_enable_o);
    foreach (rows[i]) run_row(rows[i]);
    repeat (2) @(posedge clock);
    $display("%0d rows, %0d checks, %0d errors", rows.size(), check_count, err_count);
    if (err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
